//--- hazardPkg.sv
`default_nettype none

package hazardPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int RegAddrW  = 5;  // 32 architectural registers
    localparam int NumFwdOps = 3;  // 0 ID/EX Rs1, 1 ID/EX Rs2, 2 IF/ID Rs2

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // Operand mux select toward the datapath
    typedef enum logic [1:0] {
        fwdNone  = 2'b00,  // Register file value
        fwdExMem = 2'b01,
        fwdMemWb = 2'b10,
        fwdVwb   = 2'b11   // Value written back one cycle ago
    } fwdSel_e;

    // Origin of the EX/MEM destination value
    typedef enum logic [1:0] {
        rdstAlu  = 2'b00,
        rdstMem  = 2'b01,  // Load data, not ready before WB
        rdstPc   = 2'b10,  // Link address
        rdstNone = 2'b11
    } rdstSrc_e;

    // Condition field, ARM style ordering
    typedef enum logic [3:0] {
        eq = 4'h0, ne = 4'h1, cs = 4'h2, cc = 4'h3,
        mi = 4'h4, pl = 4'h5, vs = 4'h6, vc = 4'h7,
        hi = 4'h8, ls = 4'h9, ge = 4'ha, lt = 4'hb,
        gt = 4'hc, le = 4'hd, al = 4'he, nv = 4'hf
    } cond_e;

    // Fetch address mux select
    typedef enum logic [1:0] {
        npcSeq         = 2'b00,  // PC + 4 or BTB target
        npcTarget      = 2'b01,  // Computed branch target
        npcFallthrough = 2'b10,  // Instruction after the branch
        npcIrq         = 2'b11   // Interrupt vector
    } npcSel_e;

    // 2-bit saturating counter, MSB is the prediction
    typedef enum logic [1:0] {
        strongNot   = 2'b00,
        weakNot     = 2'b01,
        weakTaken   = 2'b10,
        strongTaken = 2'b11
    } bpCnt_e;

endpackage

`default_nettype wire

//--- fwdSourceTrack.sv
`default_nettype none

module fwdSourceTrack (
    input  wire logic                             clk,
    input  wire logic                             i_rstN,
    // EX/MEM register fields
    input  wire logic                             i_exMemRWMem,     // 1 read, 0 write
    input  wire logic                             i_exMemMemEnable,
    input  wire logic                             i_exMemRWe,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_exMemRdst,
    input  wire hazardPkg::rdstSrc_e              i_exMemRdstSrc,
    // MEM/WB register fields
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_memWbRdst,
    input  wire logic                             i_memWbRWe,
    // Qualified sources
    output logic                                  o_exMemValid,
    output logic [hazardPkg::RegAddrW-1:0]        o_exMemAddr,
    output logic                                  o_exMemLoad,
    output logic                                  o_memWbValid,
    output logic [hazardPkg::RegAddrW-1:0]        o_memWbAddr,
    output logic                                  o_vwbValid,
    output logic [hazardPkg::RegAddrW-1:0]        o_vwbAddr
);

    logic                            vwbValid;
    logic [hazardPkg::RegAddrW-1:0]  vwbAddr;

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM and MEM/WB qualification
    ////////////////////////////////////////////////////////////////////////////

    // Only ALU results and link addresses exist at EX/MEM
    assign o_exMemValid = i_exMemRWe &&
                          (i_exMemRdstSrc == hazardPkg::rdstAlu ||
                           i_exMemRdstSrc == hazardPkg::rdstPc);

    // Load still on its way from the data cache
    assign o_exMemLoad  = i_exMemMemEnable && i_exMemRWMem &&
                          (i_exMemRdstSrc == hazardPkg::rdstMem);
    assign o_exMemAddr  = i_exMemRdst;

    assign o_memWbValid = i_memWbRWe;  // Any writeback is ready here
    assign o_memWbAddr  = i_memWbRdst;

    ////////////////////////////////////////////////////////////////////////////
    // Virtual write-back stage
    ////////////////////////////////////////////////////////////////////////////

    // Holds last cycle's MEM/WB write for reads that miss the RF bypass
    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            vwbValid <= 1'b0;
        end else begin
            vwbValid <= i_memWbRWe;
        end
        vwbAddr <= i_memWbRdst;  // Payload only
    end

    assign o_vwbValid = vwbValid;
    assign o_vwbAddr  = vwbAddr;

endmodule

`default_nettype wire

//--- fwdOperand.sv
`default_nettype none

module fwdOperand (
    input  wire logic                             i_need,       // Operand actually read
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_rs,
    // Sources from fwdSourceTrack
    input  wire logic                             i_exMemValid,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_exMemAddr,
    input  wire logic                             i_exMemLoad,
    input  wire logic                             i_memWbValid,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_memWbAddr,
    input  wire logic                             i_vwbValid,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_vwbAddr,
    output hazardPkg::fwdSel_e                    o_fwdSel,
    output logic                                  o_loadUse
);

    logic exMemHit;
    logic loadHit;
    logic memWbHit;
    logic vwbHit;

    assign exMemHit = i_exMemValid && (i_exMemAddr == i_rs);
    assign loadHit  = i_exMemLoad  && (i_exMemAddr == i_rs);
    assign memWbHit = i_memWbValid && (i_memWbAddr == i_rs);
    assign vwbHit   = i_vwbValid   && (i_vwbAddr   == i_rs);

    // Youngest producer wins
    always_comb begin
        o_fwdSel  = hazardPkg::fwdNone;
        o_loadUse = 1'b0;
        if (i_need) begin
            if (exMemHit) begin
                o_fwdSel = hazardPkg::fwdExMem;
            end else if (loadHit) begin
                o_loadUse = 1'b1;  // Data not back yet, hold the consumer
            end else if (memWbHit) begin
                o_fwdSel = hazardPkg::fwdMemWb;
            end else if (vwbHit) begin
                o_fwdSel = hazardPkg::fwdVwb;
            end
        end
    end

endmodule

`default_nettype wire

//--- stallUnit.sv
`default_nettype none

module stallUnit (
    input  wire logic [hazardPkg::NumFwdOps-1:0] i_loadUse,
    input  wire logic                            i_dCacheMiss,   // MEM stage
    input  wire logic                            i_iCacheMiss,   // IF stage
    input  wire logic                            i_flushPipePc,  // From branchUnit
    output logic                                 o_pcStall,
    output logic                                 o_ifIdStall,
    output logic                                 o_idExStall,
    output logic                                 o_exMemStall,
    output logic                                 o_ifIdFlush,
    output logic                                 o_idExFlush,
    output logic                                 o_exMemFlush,
    output logic                                 o_memWbFlush
);

    logic exLoadUse;  // Consumer sits in EX
    logic idLoadUse;  // Consumer sits in ID
    logic ifIdHazard;
    logic idExHazard;

    assign exLoadUse = i_loadUse[0] | i_loadUse[1];
    assign idLoadUse = i_loadUse[2];

    ////////////////////////////////////////////////////////////////////////////
    // Stall priority, oldest stage first
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        o_pcStall    = 1'b0;
        o_ifIdStall  = 1'b0;
        o_idExStall  = 1'b0;
        o_exMemStall = 1'b0;
        ifIdHazard   = 1'b0;
        idExHazard   = 1'b0;
        o_exMemFlush = 1'b0;
        o_memWbFlush = 1'b0;
        if (i_dCacheMiss) begin
            // Freeze everything up to MEM, bubble into WB
            {o_pcStall, o_ifIdStall, o_idExStall, o_exMemStall} = 4'b1111;
            o_memWbFlush = 1'b1;
        end else if (exLoadUse) begin
            {o_pcStall, o_ifIdStall, o_idExStall} = 3'b111;
            o_exMemFlush = 1'b1;
        end else if (idLoadUse) begin
            {o_pcStall, o_ifIdStall} = 2'b11;
            idExHazard = 1'b1;
        end else if (i_iCacheMiss) begin
            o_pcStall  = 1'b1;
            ifIdHazard = 1'b1;  // No valid fetch this cycle
        end
    end

    // Branch redirect kills both younger stages
    assign o_ifIdFlush = ifIdHazard | i_flushPipePc;
    assign o_idExFlush = idExHazard | i_flushPipePc;

endmodule

`default_nettype wire

//--- branchUnit.sv
`default_nettype none

module branchUnit (
    input  wire logic                 i_pcMatchValid,  // BTB hit for this branch
    input  wire logic                 i_branchInstr,
    input  wire logic                 i_jumpInstr,
    input  wire logic                 i_predicEqRes,   // BTB target equals computed one
    input  wire hazardPkg::bpCnt_e    i_ctrlIn,
    input  wire logic                 i_irq,
    input  wire logic [3:0]           i_cc4,           // N Z C V
    input  wire hazardPkg::cond_e     i_condBits,
    output hazardPkg::bpCnt_e         o_ctrlOut,
    output logic                      o_flushPipePc,
    output logic                      o_writeEnable,
    output hazardPkg::npcSel_e        o_npc
);

    logic flagN;
    logic flagZ;
    logic flagC;
    logic flagV;
    logic condPass;
    logic taken;
    logic predTaken;
    logic mispredict;

    assign {flagN, flagZ, flagC, flagV} = i_cc4;

    ////////////////////////////////////////////////////////////////////////////
    // Condition check
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        unique case (i_condBits)
            hazardPkg::eq: condPass = flagZ;
            hazardPkg::ne: condPass = !flagZ;
            hazardPkg::cs: condPass = flagC;
            hazardPkg::cc: condPass = !flagC;
            hazardPkg::mi: condPass = flagN;
            hazardPkg::pl: condPass = !flagN;
            hazardPkg::vs: condPass = flagV;
            hazardPkg::vc: condPass = !flagV;
            hazardPkg::hi: condPass = flagC && !flagZ;        // Unsigned higher
            hazardPkg::ls: condPass = !flagC || flagZ;
            hazardPkg::ge: condPass = (flagN == flagV);       // Signed compare
            hazardPkg::lt: condPass = (flagN != flagV);
            hazardPkg::gt: condPass = !flagZ && (flagN == flagV);
            hazardPkg::le: condPass = flagZ || (flagN != flagV);
            hazardPkg::al: condPass = 1'b1;
            default:       condPass = 1'b0;                   // nv
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Resolution against the prediction
    ////////////////////////////////////////////////////////////////////////////
    assign taken      = i_jumpInstr || (i_branchInstr && condPass);
    assign predTaken  = i_pcMatchValid && i_ctrlIn[1];
    assign mispredict = (taken != predTaken) ||
                        (taken && predTaken && !i_predicEqRes);  // Stale target

    always_comb begin
        o_flushPipePc = 1'b1;
        if (i_irq) begin
            o_npc = hazardPkg::npcIrq;
        end else if (mispredict && taken) begin
            o_npc = hazardPkg::npcTarget;
        end else if (mispredict) begin
            o_npc = hazardPkg::npcFallthrough;  // Fetched down the wrong path
        end else begin
            o_npc         = hazardPkg::npcSeq;
            o_flushPipePc = 1'b0;
        end
    end

    // Train only on real control transfers
    assign o_writeEnable = (i_branchInstr || i_jumpInstr) && !i_irq;

    // Saturating counter, fresh BTB entries start weak
    always_comb begin
        if (!i_pcMatchValid) begin
            o_ctrlOut = taken ? hazardPkg::weakTaken : hazardPkg::weakNot;
        end else begin
            unique case (i_ctrlIn)
                hazardPkg::strongNot:
                    o_ctrlOut = taken ? hazardPkg::weakNot : hazardPkg::strongNot;
                hazardPkg::weakNot:
                    o_ctrlOut = taken ? hazardPkg::weakTaken : hazardPkg::strongNot;
                hazardPkg::weakTaken:
                    o_ctrlOut = taken ? hazardPkg::strongTaken : hazardPkg::weakNot;
                default:
                    o_ctrlOut = taken ? hazardPkg::strongTaken : hazardPkg::weakTaken;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  wire logic                             clk,
    input  wire logic                             i_rstN,
    // Operand fields
    input  wire logic                             i_ifIdNeedRs2,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_ifIdRs2,
    input  wire logic                             i_idExNeedRs1,
    input  wire logic                             i_idExNeedRs2,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_idExRs1,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_idExRs2,
    // Destination fields
    input  wire logic                             i_exMemRWMem,
    input  wire logic                             i_exMemMemEnable,
    input  wire logic                             i_exMemRWe,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_exMemRdst,
    input  wire hazardPkg::rdstSrc_e              i_exMemRdstSrc,
    input  wire logic [hazardPkg::RegAddrW-1:0]   i_memWbRdst,
    input  wire logic                             i_memWbRWe,
    // Caches
    input  wire logic                             i_dCacheMiss,
    input  wire logic                             i_iCacheMiss,
    // Branch resolution
    input  wire logic                             i_pcMatchValid,
    input  wire logic                             i_branchInstr,
    input  wire logic                             i_jumpInstr,
    input  wire logic                             i_predicEqRes,
    input  wire hazardPkg::bpCnt_e                i_ctrlIn,
    input  wire logic                             i_irq,
    input  wire logic [3:0]                       i_cc4,
    input  wire hazardPkg::cond_e                 i_condBits,
    // Forward selects
    output hazardPkg::fwdSel_e                    o_op1ExSel,
    output hazardPkg::fwdSel_e                    o_op2ExSel,
    output hazardPkg::fwdSel_e                    o_op2IdSel,
    // Pipeline control
    output logic                                  o_pcStall,
    output logic                                  o_ifIdStall,
    output logic                                  o_idExStall,
    output logic                                  o_exMemStall,
    output logic                                  o_ifIdFlush,
    output logic                                  o_idExFlush,
    output logic                                  o_exMemFlush,
    output logic                                  o_memWbFlush,
    // Predictor and fetch
    output hazardPkg::bpCnt_e                     o_ctrlOut,
    output logic                                  o_flushPipePc,
    output logic                                  o_writeEnable,
    output hazardPkg::npcSel_e                    o_npc
);

    logic                            exMemValid, exMemLoad, memWbValid, vwbValid;
    logic [hazardPkg::RegAddrW-1:0]  exMemAddr, memWbAddr, vwbAddr;
    logic [hazardPkg::NumFwdOps-1:0] opNeed;
    logic [hazardPkg::RegAddrW-1:0]  opRs [hazardPkg::NumFwdOps];
    hazardPkg::fwdSel_e              opSel [hazardPkg::NumFwdOps];
    logic [hazardPkg::NumFwdOps-1:0] loadUse;

    // Operand order fixed by the stall priority
    assign opNeed  = {i_ifIdNeedRs2, i_idExNeedRs2, i_idExNeedRs1};
    assign opRs[0] = i_idExRs1;
    assign opRs[1] = i_idExRs2;
    assign opRs[2] = i_ifIdRs2;

    fwdSourceTrack u_fwdSourceTrack (
        .clk, .i_rstN,
        .i_exMemRWMem, .i_exMemMemEnable, .i_exMemRWe, .i_exMemRdst, .i_exMemRdstSrc,
        .i_memWbRdst, .i_memWbRWe,
        .o_exMemValid (exMemValid), .o_exMemAddr (exMemAddr), .o_exMemLoad (exMemLoad),
        .o_memWbValid (memWbValid), .o_memWbAddr (memWbAddr),
        .o_vwbValid   (vwbValid),   .o_vwbAddr   (vwbAddr)
    );

    for (genvar gi = 0; gi < hazardPkg::NumFwdOps; gi++) begin : g_op
        fwdOperand u_fwdOperand (
            .i_need       (opNeed[gi]),  .i_rs        (opRs[gi]),
            .i_exMemValid (exMemValid),  .i_exMemAddr (exMemAddr), .i_exMemLoad (exMemLoad),
            .i_memWbValid (memWbValid),  .i_memWbAddr (memWbAddr),
            .i_vwbValid   (vwbValid),    .i_vwbAddr   (vwbAddr),
            .o_fwdSel     (opSel[gi]),   .o_loadUse   (loadUse[gi])
        );
    end

    assign o_op1ExSel = opSel[0];
    assign o_op2ExSel = opSel[1];
    assign o_op2IdSel = opSel[2];

    stallUnit u_stallUnit (
        .i_loadUse (loadUse), .i_dCacheMiss, .i_iCacheMiss, .i_flushPipePc (o_flushPipePc),
        .o_pcStall, .o_ifIdStall, .o_idExStall, .o_exMemStall,
        .o_ifIdFlush, .o_idExFlush, .o_exMemFlush, .o_memWbFlush
    );

    branchUnit u_branchUnit (
        .i_pcMatchValid, .i_branchInstr, .i_jumpInstr, .i_predicEqRes, .i_ctrlIn,
        .i_irq, .i_cc4, .i_condBits,
        .o_ctrlOut, .o_flushPipePc, .o_writeEnable, .o_npc
    );

endmodule

`default_nettype wire

//--- hazardUnit_sva.sv
`default_nettype none

module hazardUnit_sva (
    input wire logic                           clk,
    input wire logic                           i_rstN,
    input wire logic                           i_dCacheMiss,
    input wire logic                           i_memWbRWe,
    input wire logic [hazardPkg::RegAddrW-1:0] i_memWbRdst,
    input wire logic [hazardPkg::RegAddrW-1:0] i_idExRs1,
    input wire logic [hazardPkg::RegAddrW-1:0] i_idExRs2,
    input wire logic [hazardPkg::RegAddrW-1:0] i_ifIdRs2,
    input wire hazardPkg::fwdSel_e             i_op1ExSel,
    input wire hazardPkg::fwdSel_e             i_op2ExSel,
    input wire hazardPkg::fwdSel_e             i_op2IdSel,
    input wire logic                           i_pcStall,
    input wire logic                           i_ifIdStall,
    input wire logic                           i_idExStall,
    input wire logic                           i_exMemStall,
    input wire logic                           i_ifIdFlush,
    input wire logic                           i_idExFlush,
    input wire logic                           i_memWbFlush,
    input wire logic                           i_flushPipePc
);

    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;  // Running count of failed relations

    // VWB only carries last cycle's MEM/WB write
    property vwbAfterWrite(sel, rs);
        @(posedge clk) disable iff (!i_rstN)
            (sel == hazardPkg::fwdVwb) |-> ($past(i_memWbRWe) && ($past(i_memWbRdst) == rs));
    endproperty

    aPcStall: assert property (@(posedge clk) disable iff (!i_rstN)
        (i_ifIdStall || i_idExStall || i_exMemStall) |-> i_pcStall)
        else begin
            assertFails++;
            $error("Stage stalled while the PC kept moving");
        end
    aMemWbFlush: assert property (@(posedge clk) disable iff (!i_rstN)
        i_memWbFlush |-> i_dCacheMiss)
        else begin
            assertFails++;
            $error("MEM/WB flushed without a data cache miss");
        end
    aBranchFlush: assert property (@(posedge clk) disable iff (!i_rstN)
        i_flushPipePc |-> (i_ifIdFlush && i_idExFlush))
        else begin
            assertFails++;
            $error("Branch flush did not reach IF/ID and ID/EX");
        end

    aVwbOp1: assert property (vwbAfterWrite(i_op1ExSel, i_idExRs1))
        else begin
            assertFails++;
            $error("ID/EX Rs1 forwarded from VWB without a write one cycle earlier");
        end
    aVwbOp2: assert property (vwbAfterWrite(i_op2ExSel, i_idExRs2))
        else begin
            assertFails++;
            $error("ID/EX Rs2 forwarded from VWB without a write one cycle earlier");
        end
    aVwbOpId: assert property (vwbAfterWrite(i_op2IdSel, i_ifIdRs2))
        else begin
            assertFails++;
            $error("IF/ID Rs2 forwarded from VWB without a write one cycle earlier");
        end

endmodule

bind hazardUnit hazardUnit_sva u_hazardUnit_sva (
    .clk, .i_rstN, .i_dCacheMiss, .i_memWbRWe, .i_memWbRdst,
    .i_idExRs1, .i_idExRs2, .i_ifIdRs2,
    .i_op1ExSel (o_op1ExSel), .i_op2ExSel (o_op2ExSel), .i_op2IdSel (o_op2IdSel),
    .i_pcStall (o_pcStall), .i_ifIdStall (o_ifIdStall),
    .i_idExStall (o_idExStall), .i_exMemStall (o_exMemStall),
    .i_ifIdFlush (o_ifIdFlush), .i_idExFlush (o_idExFlush),
    .i_memWbFlush (o_memWbFlush), .i_flushPipePc (o_flushPipePc)
);

`default_nettype wire

//--- tb_hazardUnit.sv
`default_nettype none

module tb_hazardUnit;

    timeunit 1ns;
    timeprecision 100ps;

    logic                               clk;
    logic                               i_rstN;
    logic                               i_ifIdNeedRs2, i_idExNeedRs1, i_idExNeedRs2;
    logic [hazardPkg::RegAddrW-1:0]     i_ifIdRs2, i_idExRs1, i_idExRs2;
    logic                               i_exMemRWMem, i_exMemMemEnable, i_exMemRWe;
    logic [hazardPkg::RegAddrW-1:0]     i_exMemRdst, i_memWbRdst;
    hazardPkg::rdstSrc_e                i_exMemRdstSrc;
    logic                               i_memWbRWe, i_dCacheMiss, i_iCacheMiss;
    logic                               i_pcMatchValid, i_branchInstr, i_jumpInstr;
    logic                               i_predicEqRes, i_irq;
    hazardPkg::bpCnt_e                  i_ctrlIn;
    logic [3:0]                         i_cc4;           // N Z C V
    hazardPkg::cond_e                   i_condBits;
    hazardPkg::fwdSel_e                 o_op1ExSel, o_op2ExSel, o_op2IdSel;
    logic                               o_pcStall, o_ifIdStall, o_idExStall, o_exMemStall;
    logic                               o_ifIdFlush, o_idExFlush, o_exMemFlush, o_memWbFlush;
    hazardPkg::bpCnt_e                  o_ctrlOut;
    hazardPkg::npcSel_e                 o_npc;
    logic                               o_flushPipePc, o_writeEnable;

    string      vecLines [$];        // One entry per vector line
    logic [7:0] col [24];            // Fields of the vector under test
    int         cycleCount = 0;
    int         cycleLimit = 1000;   // Replaced once the vectors are counted

    hazardUnit u_hazardUnit (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Watchdog on rising edges
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the vector loop never finished", cycleCount);
            abortRun();
        end
        if (u_hazardUnit.u_hazardUnit_sva.assertFails != 0) begin
            $display("A concurrent assertion on the hazard unit failed");
            abortRun();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic abortRun;
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkField(input string name, input logic [7:0] got,
                              input logic [7:0] exp, input int idx);
        assert (got === exp) else begin
            $display("CHECK FAILED vector %0d %s got 0x%0h expected 0x%0h", idx, name, got, exp);
            abortRun();
        end
    endtask

    // Column order as in the header of hazard_vectors.txt
    task automatic applyVector;
        {i_ifIdNeedRs2, i_idExNeedRs2, i_idExNeedRs1} = col[0][2:0];
        i_idExRs1        = col[1][hazardPkg::RegAddrW-1:0];
        i_idExRs2        = col[2][hazardPkg::RegAddrW-1:0];
        i_ifIdRs2        = col[3][hazardPkg::RegAddrW-1:0];
        {i_exMemRWMem, i_exMemMemEnable, i_exMemRWe} = col[4][2:0];
        i_exMemRdst      = col[5][hazardPkg::RegAddrW-1:0];
        i_exMemRdstSrc   = hazardPkg::rdstSrc_e'(col[6][1:0]);
        i_memWbRWe       = col[7][0];
        i_memWbRdst      = col[8][hazardPkg::RegAddrW-1:0];
        {i_dCacheMiss, i_iCacheMiss} = col[9][1:0];
        {i_pcMatchValid, i_branchInstr, i_jumpInstr, i_predicEqRes} = col[10][3:0];
        i_ctrlIn         = hazardPkg::bpCnt_e'(col[11][1:0]);
        i_irq            = col[12][0];
        i_cc4            = col[13][3:0];
        i_condBits       = hazardPkg::cond_e'(col[14][3:0]);
    endtask

    task automatic checkOutputs(input int idx);
        checkField("o_op1ExSel",    o_op1ExSel,    col[15],    idx);
        checkField("o_op2ExSel",    o_op2ExSel,    col[16],    idx);
        checkField("o_op2IdSel",    o_op2IdSel,    col[17],    idx);
        checkField("o_pcStall",     o_pcStall,     col[18][3], idx);
        checkField("o_ifIdStall",   o_ifIdStall,   col[18][2], idx);
        checkField("o_idExStall",   o_idExStall,   col[18][1], idx);
        checkField("o_exMemStall",  o_exMemStall,  col[18][0], idx);
        checkField("o_ifIdFlush",   o_ifIdFlush,   col[19][3], idx);
        checkField("o_idExFlush",   o_idExFlush,   col[19][2], idx);
        checkField("o_exMemFlush",  o_exMemFlush,  col[19][1], idx);
        checkField("o_memWbFlush",  o_memWbFlush,  col[19][0], idx);
        checkField("o_ctrlOut",     o_ctrlOut,     col[20],    idx);
        checkField("o_flushPipePc", o_flushPipePc, col[21][0], idx);
        checkField("o_writeEnable", o_writeEnable, col[22][0], idx);
        checkField("o_npc",         o_npc,         col[23],    idx);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int    fd;
        int    nRead;
        string line;

        i_rstN = 1'b0;
        {i_ifIdNeedRs2, i_idExNeedRs1, i_idExNeedRs2} = 3'b000;
        {i_ifIdRs2, i_idExRs1, i_idExRs2, i_exMemRdst} = '0;
        {i_exMemRWMem, i_exMemMemEnable, i_exMemRWe} = 3'b000;
        i_exMemRdstSrc = hazardPkg::rdstNone;
        i_memWbRWe     = 1'b1;        // Write held in reset, must not show up as VWB
        i_memWbRdst    = 5'd5;
        {i_dCacheMiss, i_iCacheMiss, i_irq} = 3'b000;
        {i_pcMatchValid, i_branchInstr, i_jumpInstr, i_predicEqRes} = 4'b0000;
        i_ctrlIn   = hazardPkg::strongNot;
        i_cc4      = 4'h0;
        i_condBits = hazardPkg::eq;

        fd = $fopen("hazard_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open hazard_vectors.txt");
            abortRun();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin  // Skip header and blanks
                vecLines.push_back(line);
            end
        end
        $fclose(fd);
        if (vecLines.size() == 0) begin
            $display("No vectors found in hazard_vectors.txt");
            abortRun();
        end
        cycleLimit = vecLines.size() + 16 + 20;  // Vectors, reset, margin

        repeat (16) @(posedge clk);
        #1;
        i_rstN = 1'b1;
        foreach (vecLines[k]) begin
            nRead = $sscanf(vecLines[k],
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
            if (nRead != 24) begin
                $display("Vector %0d holds %0d fields instead of 24", k, nRead);
                abortRun();
            end
            applyVector();
            #8;                 // Just before the next edge
            checkOutputs(k);
            @(posedge clk);
            #1;
        end

        if (u_hazardUnit.u_hazardUnit_sva.assertFails == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("A concurrent assertion on the hazard unit failed");
            abortRun();
        end
    end

endmodule

`default_nettype wire

//--- hazard_vectors.txt
# nd rs1 rs2 ir2 emC emRd emS wbW wbRd mis brC cin irq cc4 cnd sl1 sl2 sl3 stl fls cot fpc we npc
# emC=RWMem,MemEn,RWe brC=pcMatch,branch,jump,eqRes stl=pc,ifId,idEx,exMem fls=ifId,idEx,exMem,memWb
1 05 00 00 0 00 3 0 00 0 0 0 0 0 0  0 0 0 0 0 1 0 0 0
7 07 07 07 1 07 0 1 07 0 0 0 0 0 0  1 1 1 0 0 1 0 0 0
7 07 07 07 0 00 3 1 07 0 0 0 0 0 0  2 2 2 0 0 1 0 0 0
7 07 07 07 0 00 3 0 00 0 0 0 0 0 0  3 3 3 0 0 1 0 0 0
7 07 07 07 0 00 3 0 00 0 0 0 0 0 0  0 0 0 0 0 1 0 0 0
1 0a 00 00 1 0a 2 0 00 0 0 0 0 0 0  1 0 0 0 0 1 0 0 0
1 09 00 00 7 09 1 0 00 0 0 0 0 0 0  0 0 0 e 2 1 0 0 0
4 00 00 09 7 09 1 0 00 0 0 0 0 0 0  0 0 0 c 4 1 0 0 0
1 09 00 00 7 09 1 0 00 3 0 0 0 0 0  0 0 0 f 1 1 0 0 0
0 00 00 00 0 00 3 0 00 1 0 0 0 0 0  0 0 0 8 8 1 0 0 0
0 00 00 00 0 00 3 0 00 0 4 0 0 4 0  0 0 0 0 c 2 1 1 1
0 00 00 00 0 00 3 0 00 0 4 0 0 4 1  0 0 0 0 0 1 0 1 0
0 00 00 00 0 00 3 0 00 0 4 0 0 2 8  0 0 0 0 c 2 1 1 1
0 00 00 00 0 00 3 0 00 0 4 0 0 9 a  0 0 0 0 c 2 1 1 1
0 00 00 00 0 00 3 0 00 0 4 0 0 8 b  0 0 0 0 c 2 1 1 1
0 00 00 00 0 00 3 0 00 0 4 0 0 d c  0 0 0 0 0 1 0 1 0
0 00 00 00 0 00 3 0 00 0 4 0 0 f f  0 0 0 0 0 1 0 1 0
0 00 00 00 0 00 3 0 00 0 d 3 0 0 e  0 0 0 0 0 3 0 1 0
0 00 00 00 0 00 3 0 00 0 c 2 0 0 e  0 0 0 0 c 3 1 1 1
0 00 00 00 0 00 3 0 00 0 d 3 0 0 f  0 0 0 0 c 2 1 1 2
0 00 00 00 0 00 3 0 00 0 d 0 0 0 f  0 0 0 0 0 0 0 1 0
0 00 00 00 0 00 3 0 00 0 a 1 0 0 0  0 0 0 0 c 2 1 1 1
0 00 00 00 0 00 3 0 00 0 4 0 1 4 0  0 0 0 0 c 2 1 0 3
0 00 00 00 0 00 3 0 00 0 0 0 1 0 0  0 0 0 0 c 1 1 0 3
2 00 09 00 7 09 1 0 00 0 4 0 0 0 e  0 0 0 e e 2 1 1 1
0 00 00 00 0 00 3 0 00 0 0 0 0 0 0  0 0 0 0 0 1 0 0 0

//--- vlog.f
hazardPkg.sv
fwdSourceTrack.sv
fwdOperand.sv
stallUnit.sv
branchUnit.sv
hazardUnit.sv
hazardUnit_sva.sv
tb_hazardUnit.sv

//--- Bender.yml
package:
  name: hazard_unit

sources:
  - hazardPkg.sv
  - fwdSourceTrack.sv
  - fwdOperand.sv
  - stallUnit.sv
  - branchUnit.sv
  - hazardUnit.sv
  - target: test
    files:
      - hazardUnit_sva.sv
      - tb_hazardUnit.sv
